/* adapter_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module adapter_ctrl (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      req_i,
  input  wire axi_line_pkg::client_req_t req_data_i,
  output logic                           ack_o,
  output axi_line_pkg::client_rsp_t      rsp_o,
  output logic                           issue_start_o,
  output logic                           rd_line_o,
  output logic                           wr_start_o,
  output logic                           rd_start_o,
  input  wire logic                      ax_done_i,
  input  wire logic                      w_done_i,
  input  wire logic                      rd_done_i,
  input  wire axi_line_pkg::line_t       line_i,
  input  wire axi_line_pkg::id_t         rid_i,
  input  wire logic                      b_valid_i,
  input  wire axi_line_pkg::id_t         bid_i,
  output logic                           b_ready_o
);

  axi_line_pkg::ctrl_state_e state_q, state_d;
  logic ax_seen_q, ax_seen_d;
  logic w_seen_q, w_seen_d;
  logic ax_ok;
  logic w_ok;
  axi_line_pkg::client_rsp_t rsp_q, rsp_d;

  // AW and the last W beat may complete in either order
  assign ax_ok = ax_seen_q | ax_done_i;
  assign w_ok  = w_seen_q | w_done_i;

  assign rd_line_o = ~req_data_i.we & (req_data_i.kind == axi_line_pkg::LINE_REQ);
  assign ack_o     = (state_q == axi_line_pkg::DONE);
  assign b_ready_o = (state_q == axi_line_pkg::WAIT_B);
  assign rsp_o     = rsp_q;

  // ----------------------------------------------------------------------
  // transaction FSM
  // ----------------------------------------------------------------------
  always_comb begin
    state_d       = state_q;
    ax_seen_d     = ax_seen_q;
    w_seen_d      = w_seen_q;
    rsp_d         = rsp_q;
    issue_start_o = 1'b0;
    wr_start_o    = 1'b0;
    rd_start_o    = 1'b0;

    unique case (state_q)
      axi_line_pkg::IDLE: begin
        ax_seen_d = 1'b0;
        w_seen_d  = 1'b0;
        if (req_i) begin
          issue_start_o = 1'b1;
          if (req_data_i.we) begin
            wr_start_o = 1'b1;
            state_d    = axi_line_pkg::WR_ISSUE;
          end else begin
            rd_start_o = 1'b1;
            state_d    = axi_line_pkg::RD_ISSUE;
          end
        end
      end

      axi_line_pkg::WR_ISSUE: begin
        if (ax_done_i) begin
          ax_seen_d = 1'b1;
        end
        if (w_done_i) begin
          w_seen_d = 1'b1;
        end
        if (ax_ok && w_ok) begin
          state_d = axi_line_pkg::WAIT_B;
        end
      end

      axi_line_pkg::WAIT_B: begin
        if (b_valid_i) begin
          rsp_d.id = bid_i;
          state_d  = axi_line_pkg::DONE;
        end
      end

      axi_line_pkg::RD_ISSUE: begin
        if (ax_done_i) begin
          state_d = axi_line_pkg::RD_DATA;
        end
      end

      axi_line_pkg::RD_DATA: begin
        // line_i already holds the last beat in this cycle
        if (rd_done_i) begin
          rsp_d.rdata = line_i;
          rsp_d.id    = rid_i;
          state_d     = axi_line_pkg::DONE;
        end
      end

      axi_line_pkg::DONE: begin
        // hold the acknowledge until the client lets go
        if (!req_i) begin
          state_d = axi_line_pkg::IDLE;
        end
      end

      default: begin
        state_d = axi_line_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= axi_line_pkg::IDLE;
      ax_seen_q <= 1'b0;
      w_seen_q  <= 1'b0;
    end else begin
      state_q   <= state_d;
      ax_seen_q <= ax_seen_d;
      w_seen_q  <= w_seen_d;
    end
  end

  // response payload
  always_ff @(posedge clk_i) begin
    rsp_q <= rsp_d;
  end

endmodule

`default_nettype wire

/* addr_issuer.sv */
`timescale 1ns/100ps
`default_nettype none

module addr_issuer (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      start_i,
  input  wire logic                      we_i,
  input  wire logic                      rd_line_i,
  input  wire logic                      is_line_i,
  input  wire axi_line_pkg::client_req_t req_data_i,
  output logic                           aw_valid_o,
  output logic                           ar_valid_o,
  output axi_line_pkg::ax_chan_t         ax_o,
  input  wire logic                      aw_ready_i,
  input  wire logic                      ar_ready_i,
  output logic                           done_o
);

  logic                   aw_valid_q;
  logic                   ar_valid_q;
  logic                   burst;
  axi_line_pkg::ax_chan_t ax_q;

  // writes take the burst choice from the request kind, reads from the line read decode
  assign burst = we_i ? is_line_i : rd_line_i;

  assign aw_valid_o = aw_valid_q;
  assign ar_valid_o = ar_valid_q;
  assign ax_o       = ax_q;
  assign done_o     = (aw_valid_q & aw_ready_i) | (ar_valid_q & ar_ready_i);

  // address payload, captured once per request
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      ax_q.id <= req_data_i.id;
      if (burst) begin
        // line bursts start at the line base
        ax_q.addr <= {req_data_i.addr[axi_line_pkg::ADDR_W-1:axi_line_pkg::LINE_OFS],
                      {axi_line_pkg::LINE_OFS{1'b0}}};
        ax_q.len  <= 8'(axi_line_pkg::BEATS_LAST);
        ax_q.size <= 3'(axi_line_pkg::WORD_OFS);
      end else begin
        ax_q.addr <= req_data_i.addr;
        ax_q.len  <= '0;
        ax_q.size <= {1'b0, req_data_i.size};
      end
    end
  end

  // valid stays up until the slave takes the address
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      aw_valid_q <= 1'b0;
      ar_valid_q <= 1'b0;
    end else if (start_i) begin
      aw_valid_q <= we_i;
      ar_valid_q <= ~we_i;
    end else if (done_o) begin
      aw_valid_q <= 1'b0;
      ar_valid_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* axi_line_pkg.sv */
`default_nettype none

package axi_line_pkg;

  // ----------------------------------------------------------------------
  // bus and line geometry
  // ----------------------------------------------------------------------
  localparam int unsigned WORD_W     = 64;
  localparam int unsigned LINE_W     = 256;
  localparam int unsigned LINE_WORDS = LINE_W / WORD_W;
  // final beat of a line burst, also the AXI len of that burst
  localparam int unsigned BEATS_LAST = LINE_WORDS - 1;
  localparam int unsigned ADDR_W     = 64;
  localparam int unsigned ID_W       = 10;
  // byte offset bits inside a line and inside a word
  localparam int unsigned LINE_OFS   = $clog2(LINE_W / 8);
  localparam int unsigned WORD_OFS   = $clog2(WORD_W / 8);

  typedef logic [ADDR_W-1:0]            addr_t;
  typedef logic [WORD_W-1:0]            word_t;
  typedef logic [WORD_W/8-1:0]          strb_t;
  typedef logic [ID_W-1:0]              id_t;
  typedef logic [LINE_OFS-WORD_OFS-1:0] beat_idx_t;
  typedef word_t [LINE_WORDS-1:0]       line_t;
  typedef strb_t [LINE_WORDS-1:0]       line_strb_t;

  typedef enum logic {
    SINGLE_REQ = 1'b0,
    LINE_REQ   = 1'b1
  } req_kind_e;

  typedef enum logic [2:0] {
    IDLE,
    WR_ISSUE,
    WAIT_B,
    RD_ISSUE,
    RD_DATA,
    DONE
  } ctrl_state_e;

  // ----------------------------------------------------------------------
  // client side
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic       we;
    req_kind_e  kind;
    addr_t      addr;
    logic [1:0] size;   // log2 of the byte count
    id_t        id;
    line_t      wdata;
    line_strb_t be;
  } client_req_t;

  typedef struct packed {
    line_t rdata;
    id_t   id;
  } client_rsp_t;

  // ----------------------------------------------------------------------
  // bus channels
  // ----------------------------------------------------------------------
  // shared by AW and AR
  typedef struct packed {
    addr_t      addr;
    logic [7:0] len;
    logic [2:0] size;
    id_t        id;
  } ax_chan_t;

  typedef struct packed {
    word_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    word_t data;
    id_t   id;
    logic  last;
  } r_chan_t;

  typedef struct packed {
    id_t id;
  } b_chan_t;

  typedef struct packed {
    logic     aw_valid;
    ax_chan_t aw;
    logic     w_valid;
    w_chan_t  w;
    logic     ar_valid;
    ax_chan_t ar;
    logic     b_ready;
    logic     r_ready;
  } axi_req_t;

  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    logic    ar_ready;
    logic    r_valid;
    r_chan_t r;
    logic    b_valid;
    b_chan_t b;
  } axi_resp_t;

endpackage

`default_nettype wire

/* flist.f */
axi_line_pkg.sv
adapter_ctrl.sv
addr_issuer.sv
write_beat_seq.sv
read_line_buf.sv
line_adapter.sv
tb_axi_mem.sv
tb_line_adapter.sv

/* line_adapter.sv */
`timescale 1ns/100ps
`default_nettype none

module line_adapter (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      req_i,
  input  wire axi_line_pkg::client_req_t req_data_i,
  output logic                           ack_o,
  output axi_line_pkg::client_rsp_t      rsp_o,
  output logic                           crit_valid_o,
  output axi_line_pkg::word_t            crit_word_o,
  output axi_line_pkg::axi_req_t         axi_req_o,
  input  wire axi_line_pkg::axi_resp_t   axi_resp_i
);

  logic issue_start;
  logic rd_line;
  logic wr_start;
  logic rd_start;
  logic ax_done;
  logic w_done;
  logic rd_done;
  logic b_ready;
  logic aw_valid;
  logic ar_valid;
  logic w_valid;
  logic r_ready;
  axi_line_pkg::line_t    line;
  axi_line_pkg::id_t      rid;
  axi_line_pkg::ax_chan_t ax;
  axi_line_pkg::w_chan_t  w;

  // one address payload serves both AW and AR, only one valid is raised
  assign axi_req_o.aw_valid = aw_valid;
  assign axi_req_o.aw       = ax;
  assign axi_req_o.ar_valid = ar_valid;
  assign axi_req_o.ar       = ax;
  assign axi_req_o.w_valid  = w_valid;
  assign axi_req_o.w        = w;
  assign axi_req_o.b_ready  = b_ready;
  assign axi_req_o.r_ready  = r_ready;

  adapter_ctrl u_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .req_data_i    (req_data_i),
    .ack_o         (ack_o),
    .rsp_o         (rsp_o),
    .issue_start_o (issue_start),
    .rd_line_o     (rd_line),
    .wr_start_o    (wr_start),
    .rd_start_o    (rd_start),
    .ax_done_i     (ax_done),
    .w_done_i      (w_done),
    .rd_done_i     (rd_done),
    .line_i        (line),
    .rid_i         (rid),
    .b_valid_i     (axi_resp_i.b_valid),
    .bid_i         (axi_resp_i.b.id),
    .b_ready_o     (b_ready)
  );

  addr_issuer u_addr (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (issue_start),
    .we_i       (req_data_i.we),
    .rd_line_i  (rd_line),
    .is_line_i  (req_data_i.kind),
    .req_data_i (req_data_i),
    .aw_valid_o (aw_valid),
    .ar_valid_o (ar_valid),
    .ax_o       (ax),
    .aw_ready_i (axi_resp_i.aw_ready),
    .ar_ready_i (axi_resp_i.ar_ready),
    .done_o     (ax_done)
  );

  write_beat_seq u_wseq (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .start_i   (wr_start),
    .is_line_i (req_data_i.kind),
    .wdata_i   (req_data_i.wdata),
    .be_i      (req_data_i.be),
    .w_valid_o (w_valid),
    .w_o       (w),
    .w_ready_i (axi_resp_i.w_ready),
    .done_o    (w_done)
  );

  read_line_buf u_rbuf (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (rd_start),
    .is_line_i    (req_data_i.kind),
    .crit_idx_i   (req_data_i.addr[axi_line_pkg::LINE_OFS-1:axi_line_pkg::WORD_OFS]),
    .r_valid_i    (axi_resp_i.r_valid),
    .r_i          (axi_resp_i.r),
    .r_ready_o    (r_ready),
    .line_o       (line),
    .rid_o        (rid),
    .crit_valid_o (crit_valid_o),
    .crit_word_o  (crit_word_o),
    .done_o       (rd_done)
  );

endmodule

`default_nettype wire

/* read_line_buf.sv */
`timescale 1ns/100ps
`default_nettype none

module read_line_buf (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    start_i,
  input  wire logic                    is_line_i,
  input  wire axi_line_pkg::beat_idx_t crit_idx_i,
  input  wire logic                    r_valid_i,
  input  wire axi_line_pkg::r_chan_t   r_i,
  output logic                         r_ready_o,
  output axi_line_pkg::line_t          line_o,
  output axi_line_pkg::id_t            rid_o,
  output logic                         crit_valid_o,
  output axi_line_pkg::word_t          crit_word_o,
  output logic                         done_o
);

  logic                    busy_q;
  axi_line_pkg::beat_idx_t cnt_q;
  axi_line_pkg::beat_idx_t wr_idx;
  logic                    accept;
  axi_line_pkg::line_t     line_q;

  assign r_ready_o = busy_q;
  assign accept    = busy_q & r_valid_i;

  // a single read lands in word 0
  assign wr_idx = is_line_i ? cnt_q : '0;

  assign done_o = accept & r_i.last;
  assign rid_o  = r_i.id;

  // ----------------------------------------------------------------------
  // critical word
  // ----------------------------------------------------------------------
  // beats arrive from the line base, so the counter is the word offset
  assign crit_valid_o = accept & (~is_line_i | (cnt_q == crit_idx_i));
  assign crit_word_o  = r_i.data;

  // current beat merged in, so the line is complete on the last beat
  always_comb begin
    line_o = line_q;
    if (accept) begin
      line_o[wr_idx] = r_i.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      line_q <= line_o;
    end
  end

  // ----------------------------------------------------------------------
  // beat tracking
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (start_i) begin
      busy_q <= 1'b1;
      cnt_q  <= '0;
    end else if (accept) begin
      cnt_q <= cnt_q + 1'b1;
      if (r_i.last) begin
        busy_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f flist.f \
  --top-module tb_line_adapter -o sim_line_adapter
./obj_dir/sim_line_adapter > sim.log
cat sim.log

if grep -q 'All tests passed!' sim.log; then
  exit 0
else
  echo 'simulation failed, see sim.log'
  exit 1
fi

/* tb_axi_mem.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_axi_mem (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire axi_line_pkg::axi_req_t axi_req_i,
  output axi_line_pkg::axi_resp_t     axi_resp_o
);

  localparam int MEM_WORDS = 256;

  axi_line_pkg::word_t mem [0:MEM_WORDS-1];
  integer              seed;

  // write side, AW and W are collected separately
  logic                    aw_got_q;
  logic                    w_got_q;
  logic [7:0]              wbase_q;
  logic [7:0]              wlen_q;
  axi_line_pkg::id_t       wid_q;
  axi_line_pkg::beat_idx_t wcnt_q;
  axi_line_pkg::word_t     wbuf_q [0:axi_line_pkg::LINE_WORDS-1];
  axi_line_pkg::strb_t     wstrb_q [0:axi_line_pkg::LINE_WORDS-1];

  // read side
  logic                    rd_busy_q;
  logic [7:0]              rbase_q;
  logic [7:0]              rlen_q;
  logic [7:0]              rcnt_q;
  axi_line_pkg::id_t       rid_q;

  initial seed = 5055;

  // background contents, every bit of the word index shows up
  function automatic axi_line_pkg::word_t background_word(input logic [7:0] idx);
    return {8'hc3, idx, ~idx, idx ^ 8'h5a, 16'hbeef, idx, idx + 8'h71};
  endfunction

  function automatic axi_line_pkg::word_t apply_strobes(input axi_line_pkg::word_t old_w,
                                                        input axi_line_pkg::word_t new_w,
                                                        input axi_line_pkg::strb_t strb);
    axi_line_pkg::word_t res;
    res = old_w;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= background_word(8'(i));
      end
      axi_resp_o <= '0;
      aw_got_q   <= 1'b0;
      w_got_q    <= 1'b0;
      wcnt_q     <= '0;
      rd_busy_q  <= 1'b0;
      rcnt_q     <= '0;
    end else begin
      // ------------------------------------------------------------------
      // random ready stalls
      // ------------------------------------------------------------------
      axi_resp_o.aw_ready <= ($random(seed) % 4) != 0;
      axi_resp_o.w_ready  <= ($random(seed) % 4) != 0;
      axi_resp_o.ar_ready <= ($random(seed) % 4) != 0;

      if (axi_req_i.aw_valid && axi_resp_o.aw_ready) begin
        aw_got_q <= 1'b1;
        wbase_q  <= axi_req_i.aw.addr[10:3];
        wlen_q   <= axi_req_i.aw.len;
        wid_q    <= axi_req_i.aw.id;
      end
      if (axi_req_i.w_valid && axi_resp_o.w_ready) begin
        wbuf_q[wcnt_q]  <= axi_req_i.w.data;
        wstrb_q[wcnt_q] <= axi_req_i.w.strb;
        wcnt_q          <= wcnt_q + 1'b1;
        if (axi_req_i.w.last) begin
          w_got_q <= 1'b1;
        end
      end

      // the write lands only once address and all beats are in
      if (aw_got_q && w_got_q) begin
        for (int k = 0; k < axi_line_pkg::LINE_WORDS; k++) begin
          if (k <= int'(wlen_q)) begin
            mem[8'(wbase_q + k)] <= apply_strobes(mem[8'(wbase_q + k)], wbuf_q[k], wstrb_q[k]);
          end
        end
        aw_got_q           <= 1'b0;
        w_got_q            <= 1'b0;
        wcnt_q             <= '0;
        axi_resp_o.b_valid <= 1'b1;
        axi_resp_o.b.id    <= wid_q;
      end else if (axi_resp_o.b_valid && axi_req_i.b_ready) begin
        axi_resp_o.b_valid <= 1'b0;
      end

      // ------------------------------------------------------------------
      // read bursts, incrementing from the AR address
      // ------------------------------------------------------------------
      if (!rd_busy_q) begin
        if (axi_req_i.ar_valid && axi_resp_o.ar_ready) begin
          rd_busy_q <= 1'b1;
          rbase_q   <= axi_req_i.ar.addr[10:3];
          rlen_q    <= axi_req_i.ar.len;
          rid_q     <= axi_req_i.ar.id;
          rcnt_q    <= '0;
        end
      end else if (axi_resp_o.r_valid) begin
        if (axi_req_i.r_ready) begin
          axi_resp_o.r_valid <= 1'b0;
          rcnt_q             <= rcnt_q + 8'd1;
          if (axi_resp_o.r.last) begin
            rd_busy_q <= 1'b0;
          end
        end
      end else if (($random(seed) % 4) != 0) begin
        axi_resp_o.r_valid <= 1'b1;
        axi_resp_o.r.data  <= mem[8'(rbase_q + rcnt_q)];
        axi_resp_o.r.id    <= rid_q;
        axi_resp_o.r.last  <= (rcnt_q == rlen_q);
      end
    end
  end

endmodule

`default_nettype wire

/* tb_line_adapter.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_line_adapter;

  localparam int ACK_TIMEOUT = 200;
  localparam int MEM_WORDS   = 256;

  typedef struct packed {
    logic                     we;
    axi_line_pkg::req_kind_e  kind;
    axi_line_pkg::addr_t      addr;
    axi_line_pkg::id_t        id;
    axi_line_pkg::line_t      wdata;
    axi_line_pkg::line_strb_t be;
    axi_line_pkg::line_t      exp_rdata;
  } row_t;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      req;
  axi_line_pkg::client_req_t req_data;
  logic                      ack;
  axi_line_pkg::client_rsp_t rsp;
  logic                      crit_valid;
  axi_line_pkg::word_t       crit_word;
  axi_line_pkg::axi_req_t    axi_req;
  axi_line_pkg::axi_resp_t   axi_resp;

  row_t                rows [$];
  axi_line_pkg::word_t ref_mem [0:MEM_WORDS-1];
  int                  errors;
  int                  checks;
  logic                timed_out;

  line_adapter u_line_adapter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req),
    .req_data_i   (req_data),
    .ack_o        (ack),
    .rsp_o        (rsp),
    .crit_valid_o (crit_valid),
    .crit_word_o  (crit_word),
    .axi_req_o    (axi_req),
    .axi_resp_i   (axi_resp)
  );

  tb_axi_mem u_mem (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .axi_req_i  (axi_req),
    .axi_resp_o (axi_resp)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input logic [255:0] got,
                             input logic [255:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  function automatic axi_line_pkg::word_t merge_bytes(input axi_line_pkg::word_t old_w,
                                                      input axi_line_pkg::word_t new_w,
                                                      input axi_line_pkg::strb_t be);
    axi_line_pkg::word_t res;
    res = old_w;
    for (int b = 0; b < 8; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic add_row(input logic we, input axi_line_pkg::req_kind_e kind,
                         input axi_line_pkg::addr_t addr, input axi_line_pkg::id_t id,
                         input axi_line_pkg::line_t wdata,
                         input axi_line_pkg::line_strb_t be);
    row_t r;
    r       = '0;
    r.we    = we;
    r.kind  = kind;
    r.addr  = addr;
    r.id    = id;
    r.wdata = wdata;
    r.be    = be;
    rows.push_back(r);
  endtask

  // walk the table through the reference memory to fill in read data
  task automatic predict_reads();
    row_t       r;
    logic [7:0] idx;
    for (int n = 0; n < rows.size(); n++) begin
      r = rows[n];
      for (int k = 0; k < axi_line_pkg::LINE_WORDS; k++) begin
        if (r.kind == axi_line_pkg::LINE_REQ) begin
          idx = {r.addr[10:5], 2'(k)};
        end else begin
          idx = r.addr[10:3];
        end
        if (r.kind == axi_line_pkg::LINE_REQ || k == 0) begin
          if (r.we) begin
            ref_mem[idx] = merge_bytes(ref_mem[idx], r.wdata[k], r.be[k]);
          end else begin
            r.exp_rdata[k] = ref_mem[idx];
          end
        end
      end
      rows[n] = r;
    end
  endtask

  task automatic idle_check(input int n);
    repeat (n) begin
      @(negedge clk_i);
      checks++;
      if (ack || crit_valid) begin
        errors++;
        $display("Unexpected acknowledge or critical word at %0t without a request", $time);
      end
    end
  endtask

  task automatic run_row(input row_t r);
    axi_line_pkg::client_req_t cr;
    axi_line_pkg::ax_chan_t    ax_exp;
    axi_line_pkg::word_t       crit_seen;
    axi_line_pkg::word_t       crit_exp;
    int                        cyc;
    int                        crit_cnt;
    cr        = '0;
    cr.we     = r.we;
    cr.kind   = r.kind;
    cr.addr   = r.addr;
    cr.size   = 2'd3;
    cr.id     = r.id;
    cr.wdata  = r.wdata;
    cr.be     = r.be;
    crit_seen = '0;
    crit_cnt  = 0;
    cyc       = 0;
    crit_exp  = (r.kind == axi_line_pkg::LINE_REQ) ? r.exp_rdata[r.addr[4:3]] : r.exp_rdata[0];
    ax_exp    = '0;
    ax_exp.id = r.id;
    if (r.kind == axi_line_pkg::LINE_REQ) begin
      // four 64-bit beats from the line base
      ax_exp.addr = r.addr & ~64'h1f;
      ax_exp.len  = 8'd3;
      ax_exp.size = 3'd3;
    end else begin
      ax_exp.addr = r.addr;
      ax_exp.len  = 8'd0;
      ax_exp.size = 3'(cr.size);
    end
    @(posedge clk_i);
    req_data <= cr;
    req      <= 1'b1;
    while (!ack && cyc < ACK_TIMEOUT) begin
      @(negedge clk_i);
      cyc++;
      if (crit_valid) begin
        crit_cnt++;
        crit_seen = crit_word;
      end
      // only the address channel of the request's direction may be valid
      if (axi_req.aw_valid || axi_req.ar_valid) begin
        check_value("axi_req_o.aw_valid", axi_req.aw_valid, r.we);
        check_value("axi_req_o.ar_valid", axi_req.ar_valid, !r.we);
        if (r.we) begin
          check_value("axi_req_o.aw", axi_req.aw, ax_exp);
        end else begin
          check_value("axi_req_o.ar", axi_req.ar, ax_exp);
        end
      end
    end
    if (!ack) begin
      errors++;
      timed_out = 1'b1;
      $display("Timeout waiting for ack_o on request id %0d", r.id);
    end else begin
      // issue, data and done take at least three cycles
      if (cyc < 3) begin
        errors++;
        $display("ack_o rose after only %0d cycles for request id %0d", cyc, r.id);
      end
      check_value("rsp_o.id", rsp.id, r.id);
      if (r.we) begin
        check_value("crit_valid_o pulse count", crit_cnt, 0);
      end else begin
        if (r.kind == axi_line_pkg::LINE_REQ) begin
          check_value("rsp_o.rdata", rsp.rdata, r.exp_rdata);
        end else begin
          check_value("rsp_o.rdata[0]", rsp.rdata[0], r.exp_rdata[0]);
        end
        check_value("crit_valid_o pulse count", crit_cnt, 1);
        check_value("crit_word_o", crit_seen, crit_exp);
      end
      @(posedge clk_i);
      req <= 1'b0;
      cyc = 0;
      while (ack && cyc < ACK_TIMEOUT) begin
        @(negedge clk_i);
        cyc++;
      end
      if (ack) begin
        errors++;
        timed_out = 1'b1;
        $display("Timeout waiting for ack_o to fall on request id %0d", r.id);
      end else if (cyc != 2) begin
        errors++;
        $display("ack_o did not fall one cycle after req_i was seen low, id %0d", r.id);
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // stimulus table and main sequence
  // ----------------------------------------------------------------------
  initial begin
    rst_ni    = 1'b0;
    req       = 1'b0;
    req_data  = '0;
    errors    = 0;
    checks    = 0;
    timed_out = 1'b0;

    add_row(1'b1, axi_line_pkg::SINGLE_REQ, 64'h108, 10'h011,
            {192'h0, 64'h1122_3344_5566_7788}, {24'h0, 8'h0f});
    add_row(1'b0, axi_line_pkg::SINGLE_REQ, 64'h108, 10'h012, '0, '0);
    add_row(1'b1, axi_line_pkg::LINE_REQ, 64'h200, 10'h013,
            {64'hd3d3_0003_a0a0_3333, 64'hd2d2_0002_a0a0_2222,
             64'hd1d1_0001_a0a0_1111, 64'hd0d0_0000_a0a0_0000}, '1);
    add_row(1'b0, axi_line_pkg::LINE_REQ, 64'h218, 10'h014, '0, '0);
    add_row(1'b0, axi_line_pkg::LINE_REQ, 64'h20c, 10'h015, '0, '0);
    add_row(1'b1, axi_line_pkg::LINE_REQ, 64'h340, 10'h1a0,
            {64'h0123_4567_89ab_cdef, 64'hfeed_face_cafe_f00d,
             64'h5555_aaaa_5555_aaaa, 64'h7777_8888_9999_0000},
            {8'hf0, 8'h00, 8'hff, 8'h3c});
    add_row(1'b0, axi_line_pkg::SINGLE_REQ, 64'h350, 10'h1a1, '0, '0);
    add_row(1'b1, axi_line_pkg::SINGLE_REQ, 64'h358, 10'h2f0,
            {192'h0, 64'hbbbb_cccc_dddd_eeee}, {24'h0, 8'hf0});
    add_row(1'b0, axi_line_pkg::LINE_REQ, 64'h350, 10'h2f1, '0, '0);
    add_row(1'b0, axi_line_pkg::SINGLE_REQ, 64'h040, 10'h3ff, '0, '0);
    add_row(1'b0, axi_line_pkg::LINE_REQ, 64'h7e8, 10'h155, '0, '0);
    add_row(1'b1, axi_line_pkg::SINGLE_REQ, 64'h7f0, 10'h0aa,
            {192'h0, 64'h0f0f_1e1e_2d2d_3c3c}, {24'h0, 8'hff});
    add_row(1'b0, axi_line_pkg::LINE_REQ, 64'h7f0, 10'h2ab, '0, '0);

    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;

    // reference starts from the bus model's background contents
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i] = u_mem.mem[i];
    end
    predict_reads();

    idle_check(8);
    check_value("aw_valid", axi_req.aw_valid, 1'b0);
    check_value("w_valid", axi_req.w_valid, 1'b0);
    check_value("ar_valid", axi_req.ar_valid, 1'b0);
    check_value("r_ready", axi_req.r_ready, 1'b0);
    check_value("b_ready", axi_req.b_ready, 1'b0);

    for (int i = 0; i < rows.size() && !timed_out; i++) begin
      run_row(rows[i]);
      if (!timed_out) begin
        idle_check(2);
      end
    end

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* write_beat_seq.sv */
`timescale 1ns/100ps
`default_nettype none

module write_beat_seq (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic                     start_i,
  input  wire logic                     is_line_i,
  input  wire axi_line_pkg::line_t      wdata_i,
  input  wire axi_line_pkg::line_strb_t be_i,
  output logic                          w_valid_o,
  output axi_line_pkg::w_chan_t         w_o,
  input  wire logic                     w_ready_i,
  output logic                          done_o
);

  logic                    active_q;
  axi_line_pkg::beat_idx_t cnt_q;
  logic                    accept;

  assign w_valid_o = active_q;

  // ----------------------------------------------------------------------
  // beat payload
  // ----------------------------------------------------------------------
  // a single write never advances the counter, so it sends word 0
  assign w_o.data = wdata_i[cnt_q];
  assign w_o.strb = be_i[cnt_q];
  assign w_o.last = ~is_line_i |
                    (cnt_q == axi_line_pkg::beat_idx_t'(axi_line_pkg::BEATS_LAST));

  assign accept = active_q & w_ready_i;
  assign done_o = accept & w_o.last;

  // ----------------------------------------------------------------------
  // beat counter
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      cnt_q    <= '0;
    end else if (start_i) begin
      active_q <= 1'b1;
      cnt_q    <= '0;
    end else if (accept) begin
      cnt_q <= cnt_q + 1'b1;
      // drop valid once the last beat is taken
      if (w_o.last) begin
        active_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire
